//--- src/mipsPkg.sv
package mipsPkg;

	// primary opcode field, bits 31:26.
	localparam logic [5:0] OP_SPECIAL  = 6'b000000;
	localparam logic [5:0] OP_REGIMM   = 6'b000001;
	localparam logic [5:0] OP_J        = 6'b000010;
	localparam logic [5:0] OP_JAL      = 6'b000011;
	localparam logic [5:0] OP_BEQ      = 6'b000100;
	localparam logic [5:0] OP_BNE      = 6'b000101;
	localparam logic [5:0] OP_BLEZ     = 6'b000110;
	localparam logic [5:0] OP_BGTZ     = 6'b000111;
	localparam logic [5:0] OP_ADDI     = 6'b001000;
	localparam logic [5:0] OP_ADDIU    = 6'b001001;
	localparam logic [5:0] OP_SLTI     = 6'b001010;
	localparam logic [5:0] OP_SLTIU    = 6'b001011;
	localparam logic [5:0] OP_ANDI     = 6'b001100;
	localparam logic [5:0] OP_ORI      = 6'b001101;
	localparam logic [5:0] OP_XORI     = 6'b001110;
	localparam logic [5:0] OP_LUI      = 6'b001111;
	localparam logic [5:0] OP_COP0     = 6'b010000;
	localparam logic [5:0] OP_SPECIAL2 = 6'b011100;
	localparam logic [5:0] OP_SPECIAL3 = 6'b011111;
	localparam logic [5:0] OP_LB       = 6'b100000;
	localparam logic [5:0] OP_LH       = 6'b100001;
	localparam logic [5:0] OP_LWL      = 6'b100010;
	localparam logic [5:0] OP_LW       = 6'b100011;
	localparam logic [5:0] OP_LBU      = 6'b100100;
	localparam logic [5:0] OP_LHU      = 6'b100101;
	localparam logic [5:0] OP_LWR      = 6'b100110;
	localparam logic [5:0] OP_SB       = 6'b101000;
	localparam logic [5:0] OP_SH       = 6'b101001;
	localparam logic [5:0] OP_SWL      = 6'b101010;
	localparam logic [5:0] OP_SW       = 6'b101011;
	localparam logic [5:0] OP_SWR      = 6'b101110;
	localparam logic [5:0] OP_LL       = 6'b110000;

	// funct field under SPECIAL.
	localparam logic [5:0] FN_SLL     = 6'b000000;
	localparam logic [5:0] FN_SRL     = 6'b000010;
	localparam logic [5:0] FN_SRA     = 6'b000011;
	localparam logic [5:0] FN_SLLV    = 6'b000100;
	localparam logic [5:0] FN_SRLV    = 6'b000110;
	localparam logic [5:0] FN_SRAV    = 6'b000111;
	localparam logic [5:0] FN_JR      = 6'b001000;
	localparam logic [5:0] FN_JALR    = 6'b001001;
	localparam logic [5:0] FN_MOVZ    = 6'b001010;
	localparam logic [5:0] FN_MOVN    = 6'b001011;
	localparam logic [5:0] FN_SYSCALL = 6'b001100;
	localparam logic [5:0] FN_BREAK   = 6'b001101;
	localparam logic [5:0] FN_MFHI    = 6'b010000;
	localparam logic [5:0] FN_MTHI    = 6'b010001;
	localparam logic [5:0] FN_MFLO    = 6'b010010;
	localparam logic [5:0] FN_MTLO    = 6'b010011;
	localparam logic [5:0] FN_MULT    = 6'b011000;
	localparam logic [5:0] FN_MULTU   = 6'b011001;
	localparam logic [5:0] FN_DIV     = 6'b011010;
	localparam logic [5:0] FN_DIVU    = 6'b011011;
	localparam logic [5:0] FN_ADD     = 6'b100000;
	localparam logic [5:0] FN_ADDU    = 6'b100001;
	localparam logic [5:0] FN_SUB     = 6'b100010;
	localparam logic [5:0] FN_SUBU    = 6'b100011;
	localparam logic [5:0] FN_AND     = 6'b100100;
	localparam logic [5:0] FN_OR      = 6'b100101;
	localparam logic [5:0] FN_XOR     = 6'b100110;
	localparam logic [5:0] FN_NOR     = 6'b100111;
	localparam logic [5:0] FN_SLT     = 6'b101010;
	localparam logic [5:0] FN_SLTU    = 6'b101011;

	// funct field under SPECIAL2.
	localparam logic [5:0] FN2_MADD  = 6'b000000;
	localparam logic [5:0] FN2_MADDU = 6'b000001;
	localparam logic [5:0] FN2_MUL   = 6'b000010;
	localparam logic [5:0] FN2_MSUB  = 6'b000100;
	localparam logic [5:0] FN2_MSUBU = 6'b000101;
	localparam logic [5:0] FN2_CLZ   = 6'b100000;
	localparam logic [5:0] FN2_CLO   = 6'b100001;

	// funct field under SPECIAL3, BSHFL picks its op from shamt.
	localparam logic [5:0] FN3_EXT   = 6'b000000;
	localparam logic [5:0] FN3_INS   = 6'b000100;
	localparam logic [5:0] FN3_BSHFL = 6'b100000;
	localparam logic [4:0] SH_WSBH   = 5'b00010;
	localparam logic [4:0] SH_SEB    = 5'b10000;
	localparam logic [4:0] SH_SEH    = 5'b11000;

	// rt field under REGIMM.
	localparam logic [4:0] RT_BLTZ   = 5'b00000;
	localparam logic [4:0] RT_BGEZ   = 5'b00001;
	localparam logic [4:0] RT_BLTZAL = 5'b10000;
	localparam logic [4:0] RT_BGEZAL = 5'b10001;

	// rs field under COP0.
	localparam logic [4:0] RS_MF = 5'b00000;
	localparam logic [4:0] RS_MT = 5'b00100;

	localparam logic [31:0] ERET_WORD = 32'h4200_0018;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFmt_t;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iFmt_t;

	typedef struct packed {
		logic [5:0] op;
		logic [25:0] target;
	} jFmt_t;

	// one instruction word, three field layouts.
	typedef union packed {
		rFmt_t rFmt;
		iFmt_t iFmt;
		jFmt_t jFmt;
	} instrWord_u;

	// up to sixteen characters, right-justified, zero-filled on the left.
	typedef logic [127:0] mnemonic_t;

	typedef enum logic [2:0] {
		clsNop,
		clsAlu,
		clsBranch,
		clsJump,
		clsLoad,
		clsStore,
		clsSystem,
		clsUnknown
	} insnClass_e;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
		mnemonic_t mnem;
		insnClass_e cls;
	} traceRec_t;

endpackage

//--- src/instDec.sv
module instDec (
	input mipsPkg::instrWord_u instr,
	output mipsPkg::mnemonic_t mnem,
	output mipsPkg::insnClass_e cls
);
	import mipsPkg::*;

	typedef struct packed {
		mnemonic_t mnem;
		insnClass_e cls;
	} decOut_t;

	decOut_t dec;

	function automatic decOut_t entry(input mnemonic_t m, input insnClass_e c);
		decOut_t d;
		d.mnem = m;
		d.cls = c;
		return d;
	endfunction

	always_comb begin
		dec = entry("N-R", clsUnknown);
		case (instr.iFmt.op)
			OP_SPECIAL: begin
				case (instr.rFmt.funct)
					FN_ADD:     dec = entry("ADD", clsAlu);
					FN_ADDU:    dec = entry("ADDU", clsAlu);
					FN_SUB:     dec = entry("SUB", clsAlu);
					FN_SUBU:    dec = entry("SUBU", clsAlu);
					FN_SLTU:    dec = entry("SLTU", clsAlu);
					FN_SLT:     dec = entry("SLT", clsAlu);
					FN_AND:     dec = entry("AND", clsAlu);
					FN_NOR:     dec = entry("NOR", clsAlu);
					FN_OR:      dec = entry("OR", clsAlu);
					FN_XOR:     dec = entry("XOR", clsAlu);
					FN_SLLV:    dec = entry("SLLV", clsAlu);
					FN_SLL:     dec = entry("SLL", clsAlu);
					FN_SRAV:    dec = entry("SRAV", clsAlu);
					FN_SRA:     dec = entry("SRA", clsAlu);
					FN_MOVN:    dec = entry("MOVN", clsAlu);
					FN_MOVZ:    dec = entry("MOVZ", clsAlu);
					FN_MFHI:    dec = entry("MFHI", clsAlu);
					FN_MFLO:    dec = entry("MFLO", clsAlu);
					FN_SRL:     dec = entry("SRL", clsAlu);
					FN_SRLV:    dec = entry("SRLV", clsAlu);
					FN_MULT:    dec = entry("MULT", clsAlu);
					FN_MULTU:   dec = entry("MULTU", clsAlu);
					FN_DIV:     dec = entry("DIV", clsAlu);
					FN_DIVU:    dec = entry("DIVU", clsAlu);
					FN_MTHI:    dec = entry("MTHI", clsAlu);
					FN_MTLO:    dec = entry("MTLO", clsAlu);
					FN_JR:      dec = entry("JR", clsJump);
					FN_JALR:    dec = entry("JALR", clsJump);
					FN_SYSCALL: dec = entry("SYSCALL", clsSystem);
					FN_BREAK:   dec = entry("BREAK", clsSystem);
					default:    dec = entry("N-R", clsUnknown);
				endcase
			end

			// immediate alu ops.
			OP_ADDI:  dec = entry("ADDI", clsAlu);
			OP_ADDIU: dec = entry("ADDIU", clsAlu);
			OP_SLTI:  dec = entry("SLTI", clsAlu);
			OP_SLTIU: dec = entry("SLTIU", clsAlu);
			OP_ANDI:  dec = entry("ANDI", clsAlu);
			OP_ORI:   dec = entry("ORI", clsAlu);
			OP_XORI:  dec = entry("XORI", clsAlu);
			OP_LUI:   dec = entry("LUI", clsAlu);

			OP_BEQ:  dec = entry("BEQ", clsBranch);
			OP_BNE:  dec = entry("BNE", clsBranch);
			OP_BLEZ: dec = entry("BLEZ", clsBranch);
			OP_BGTZ: dec = entry("BGTZ", clsBranch);
			OP_REGIMM: begin
				case (instr.iFmt.rt)
					RT_BLTZ:   dec = entry("BLTZ", clsBranch);
					RT_BGEZ:   dec = entry("BGEZ", clsBranch);
					RT_BLTZAL: dec = entry("BLTZAL", clsBranch);
					RT_BGEZAL: dec = entry("BGEZAL", clsBranch);
					default:   dec = entry("N-R", clsUnknown);
				endcase
			end

			OP_J:   dec = entry("J", clsJump);
			OP_JAL: dec = entry("JAL", clsJump);

			// loads and stores, all i-format.
			OP_LB:  dec = entry("LB", clsLoad);
			OP_LBU: dec = entry("LBU", clsLoad);
			OP_LH:  dec = entry("LH", clsLoad);
			OP_LHU: dec = entry("LHU", clsLoad);
			OP_LW:  dec = entry("LW", clsLoad);
			OP_LWL: dec = entry("LWL", clsLoad);
			OP_LWR: dec = entry("LWR", clsLoad);
			OP_LL:  dec = entry("LL", clsLoad);
			OP_SB:  dec = entry("SB", clsStore);
			OP_SH:  dec = entry("SH", clsStore);
			OP_SW:  dec = entry("SW", clsStore);
			OP_SWL: dec = entry("SWL", clsStore);
			OP_SWR: dec = entry("SWR", clsStore);

			OP_COP0: begin
				case (instr.rFmt.rs)
					RS_MF:   dec = entry("MFC0", clsSystem);
					RS_MT:   dec = entry("MTC0", clsSystem);
					default: dec = entry("N-R", clsUnknown);
				endcase
			end

			OP_SPECIAL2: begin
				case (instr.rFmt.funct)
					FN2_CLO:   dec = entry("CLO", clsAlu);
					FN2_CLZ:   dec = entry("CLZ", clsAlu);
					FN2_MUL:   dec = entry("MUL", clsAlu);
					FN2_MADD:  dec = entry("MADD", clsAlu);
					FN2_MADDU: dec = entry("MADDU", clsAlu);
					FN2_MSUB:  dec = entry("MSUB", clsAlu);
					FN2_MSUBU: dec = entry("MSUBU", clsAlu);
					default:   dec = entry("N-R", clsUnknown);
				endcase
			end

			OP_SPECIAL3: begin
				case (instr.rFmt.funct)
					FN3_BSHFL: begin
						case (instr.rFmt.shamt)
							SH_SEB:  dec = entry("SEB", clsAlu);
							SH_SEH:  dec = entry("SEH", clsAlu);
							SH_WSBH: dec = entry("WSBH", clsAlu);
							default: dec = entry("N-R", clsUnknown);
						endcase
					end
					FN3_EXT: dec = entry("EXT", clsAlu);
					FN3_INS: dec = entry("INS", clsAlu);
					default: dec = entry("N-R", clsUnknown);
				endcase
			end

			default: dec = entry("N-R", clsUnknown);
		endcase

		// whole-word matches win over the table, NOP last so it beats SLL.
		if (instr == ERET_WORD) begin
			dec = entry("ERET", clsSystem);
		end
		if (instr == '0) begin
			dec = entry("NOP", clsNop);
		end
	end

	assign mnem = dec.mnem;
	assign cls = dec.cls;

endmodule

//--- src/traceStage.sv
module traceStage (
	input logic clk,
	input logic rst,
	input logic retValid,
	input logic [31:0] retPc,
	input logic [31:0] retInstr,
	input mipsPkg::mnemonic_t mnem,
	input mipsPkg::insnClass_e cls,
	output logic traceValid,
	output mipsPkg::traceRec_t trace
);

	// one-cycle pulse after each retirement.
	always_ff @(posedge clk) begin
		if (rst) begin
			traceValid <= 1'b0;
		end else begin
			traceValid <= retValid;
		end
	end

	// record only loads on retValid, so it holds between pulses.
	always_ff @(posedge clk) begin
		if (rst) begin
			trace <= '0;
		end else if (retValid) begin
			trace.pc <= retPc;
			trace.instr <= retInstr;
			trace.mnem <= mnem;
			trace.cls <= cls;
		end
	end

endmodule

//--- src/classCounter.sv
module classCounter #(
	parameter int CNT_W = 16
) (
	input logic clk,
	input logic rst,
	input logic retValid,
	input mipsPkg::insnClass_e cls,
	input mipsPkg::insnClass_e cntSel,
	output logic [CNT_W-1:0] cntValue
);

	// one counter per class, indexed by the enum value.
	logic [7:0][CNT_W-1:0] cnt;
	logic atMax;

	assign atMax = &cnt[cls];

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (retValid && !atMax) begin
			cnt[cls] <= cnt[cls] + 1'b1;
		end
	end

	// read side is a plain mux.
	assign cntValue = cnt[cntSel];

endmodule

//--- src/instTrace.sv
module instTrace #(
	parameter int CNT_W = 16
) (
	input logic clk,
	input logic rst,
	input logic retValid,
	input logic [31:0] retPc,
	input logic [31:0] retInstr,
	output logic traceValid,
	output mipsPkg::traceRec_t trace,
	input mipsPkg::insnClass_e cntSel,
	output logic [CNT_W-1:0] cntValue
);
	import mipsPkg::*;

	mnemonic_t mnem;
	insnClass_e cls;

	instDec u_instDec (
		.instr(retInstr),
		.mnem(mnem),
		.cls(cls)
	);

	traceStage u_traceStage (
		.clk(clk),
		.rst(rst),
		.retValid(retValid),
		.retPc(retPc),
		.retInstr(retInstr),
		.mnem(mnem),
		.cls(cls),
		.traceValid(traceValid),
		.trace(trace)
	);

	classCounter #(
		.CNT_W(CNT_W)
	) u_classCounter (
		.clk(clk),
		.rst(rst),
		.retValid(retValid),
		.cls(cls),
		.cntSel(cntSel),
		.cntValue(cntValue)
	);

endmodule

//--- test/instTrace_chk.sv
module instTrace_chk #(
	parameter int CNT_W = 16
) (
	input logic clk,
	input logic rst,
	input logic retValid,
	input logic traceValid,
	input mipsPkg::insnClass_e cntSel,
	input logic [CNT_W-1:0] cntValue
);

	// a trace pulse always follows a retirement on the previous edge.
	assert property (@(posedge clk) disable iff (rst) traceValid |-> $past(retValid))
		else $error("traceValid without retValid on the previous cycle");

	// counters only count up, or hold once saturated.
	assert property (@(posedge clk) disable iff (rst)
		$stable(cntSel) |-> cntValue >= $past(cntValue))
		else $error("selected counter decreased");

	assert property (@(posedge clk) $fell(rst) |-> cntValue == '0)
		else $error("counter nonzero right after reset");

endmodule

bind instTrace instTrace_chk #(
	.CNT_W(CNT_W)
) u_chk (
	.clk(clk),
	.rst(rst),
	.retValid(retValid),
	.traceValid(traceValid),
	.cntSel(cntSel),
	.cntValue(cntValue)
);

//--- test/tb_instTrace.sv
module tb_instTrace;
	import mipsPkg::*;

	localparam int N_SWEEP = 355;
	localparam int N_RAND = 200;
	localparam int N_GAP = 100;
	localparam int N_NOP = 300;
	// reset, stimulus, four counter reads of three cycles, final drain, then margin.
	localparam int LIMIT = 8 + N_SWEEP + N_RAND + N_GAP + N_NOP + 4 * 3 + 2 + 50;

	// MIPS32 SPECIAL names by funct, zero where undefined.
	localparam mnemonic_t SPEC_NAME [48] = '{
		"SLL", '0, "SRL", "SRA", "SLLV", '0, "SRLV", "SRAV",
		"JR", "JALR", "MOVZ", "MOVN", "SYSCALL", "BREAK", '0, '0,
		"MFHI", "MTHI", "MFLO", "MTLO", '0, '0, '0, '0,
		"MULT", "MULTU", "DIV", "DIVU", '0, '0, '0, '0,
		"ADD", "ADDU", "SUB", "SUBU", "AND", "OR", "XOR", "NOR",
		'0, '0, "SLT", "SLTU", '0, '0, '0, '0
	};

	// names for opcodes that need no sub-code.
	localparam mnemonic_t OP_NAME [49] = '{
		'0, '0, "J", "JAL", "BEQ", "BNE", "BLEZ", "BGTZ",
		"ADDI", "ADDIU", "SLTI", "SLTIU", "ANDI", "ORI", "XORI", "LUI",
		'0, '0, '0, '0, '0, '0, '0, '0,
		'0, '0, '0, '0, '0, '0, '0, '0,
		"LB", "LH", "LWL", "LW", "LBU", "LHU", "LWR", '0,
		"SB", "SH", "SWL", "SW", '0, '0, "SWR", '0,
		"LL"
	};

	logic clk;
	logic rst;
	logic retValid;
	logic [31:0] retPc;
	logic [31:0] retInstr;
	logic traceValid;
	traceRec_t trace;
	insnClass_e cntSel;
	logic [7:0] cntValue;

	logic [31:0] rng;
	logic [31:0] pc;
	logic [31:0] sweep[$];
	logic [31:0] known[$];
	traceRec_t expQ[$];
	traceRec_t expRec;
	int modelCnt [8];
	int errors;
	int checks;
	int cycles;

	instTrace #(
		.CNT_W(8)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.retValid(retValid),
		.retPc(retPc),
		.retInstr(retInstr),
		.traceValid(traceValid),
		.trace(trace),
		.cntSel(cntSel),
		.cntValue(cntValue)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// expected record from the MIPS32 opcode map, written out by encoding.
	function automatic traceRec_t refDecode(input logic [31:0] addr, input instrWord_u w);
		traceRec_t r;
		logic [5:0] op;
		op = w.rFmt.op;
		r.pc = addr;
		r.instr = w;
		r.mnem = '0;
		case (op)
			6'h00: if (w.rFmt.funct < 6'd48) r.mnem = SPEC_NAME[w.rFmt.funct];
			6'h01: case (w.iFmt.rt)
				5'd0: r.mnem = "BLTZ";
				5'd1: r.mnem = "BGEZ";
				5'd16: r.mnem = "BLTZAL";
				5'd17: r.mnem = "BGEZAL";
			endcase
			6'h10: case (w.rFmt.rs)
				5'd0: r.mnem = "MFC0";
				5'd4: r.mnem = "MTC0";
			endcase
			6'h1c: case (w.rFmt.funct)
				6'd0: r.mnem = "MADD";
				6'd1: r.mnem = "MADDU";
				6'd2: r.mnem = "MUL";
				6'd4: r.mnem = "MSUB";
				6'd5: r.mnem = "MSUBU";
				6'd32: r.mnem = "CLZ";
				6'd33: r.mnem = "CLO";
			endcase
			6'h1f: case (w.rFmt.funct)
				6'd0: r.mnem = "EXT";
				6'd4: r.mnem = "INS";
				6'd32: case (w.rFmt.shamt)
					5'd2: r.mnem = "WSBH";
					5'd16: r.mnem = "SEB";
					5'd24: r.mnem = "SEH";
				endcase
			endcase
			default: if (op < 6'd49) r.mnem = OP_NAME[op];
		endcase
		if (r.mnem == '0) r.mnem = "N-R";
		if (w == 32'h4200_0018) r.mnem = "ERET";
		if (w == '0) r.mnem = "NOP";
		// class follows from the name and the opcode group.
		if (r.mnem == "N-R") r.cls = clsUnknown;
		else if (r.mnem == "NOP") r.cls = clsNop;
		else if (r.mnem inside {"SYSCALL", "BREAK", "MFC0", "MTC0", "ERET"})
			r.cls = clsSystem;
		else if (r.mnem inside {"J", "JAL", "JR", "JALR"}) r.cls = clsJump;
		else if (op == 6'h01 || op[5:2] == 4'b0001) r.cls = clsBranch;
		else if (op[5:3] == 3'b100 || op == 6'h30) r.cls = clsLoad;
		else if (op[5:3] == 3'b101) r.cls = clsStore;
		else r.cls = clsAlu;
		return r;
	endfunction

	task automatic checkEq(input logic [127:0] got, input logic [127:0] want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, want);
		end
	endtask

	// every opcode, then every sub-code of each family, with random filler fields.
	task automatic buildSweep();
		traceRec_t e;
		for (int i = 0; i < 64; i++) begin
			rng = xorshift(rng);
			sweep.push_back({i[5:0], rng[25:0]});
			sweep.push_back({6'h00, rng[25:6], i[5:0]});
			sweep.push_back({6'h1c, rng[25:6], i[5:0]});
			sweep.push_back({6'h1f, rng[25:6], i[5:0]});
			if (i < 32) begin
				sweep.push_back({6'h01, rng[25:21], i[4:0], rng[15:0]});
				sweep.push_back({6'h10, i[4:0], rng[20:0]});
				sweep.push_back({6'h1f, rng[25:11], i[4:0], 6'h20});
			end
		end
		sweep.push_back(32'h0000_0000);
		sweep.push_back(32'h4200_0018);
		sweep.push_back(32'h0002_1080);
		foreach (sweep[i]) begin
			e = refDecode(32'h0, sweep[i]);
			if (e.cls != clsUnknown) known.push_back(sweep[i]);
		end
	endtask

	// about a fifth fully random, the rest from the known encodings.
	function automatic logic [31:0] pickWord();
		logic [31:0] sel;
		rng = xorshift(rng);
		sel = rng;
		rng = xorshift(rng);
		if (sel % 5 == 0) return rng;
		return known[rng % known.size()];
	endfunction

	task automatic idle(input int n);
		retValid = 1'b0;
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic retire(input logic [31:0] w);
		traceRec_t e;
		e = refDecode(pc, w);
		expQ.push_back(e);
		if (modelCnt[e.cls] != 255) modelCnt[e.cls]++;
		retValid = 1'b1;
		retPc = pc;
		retInstr = w;
		pc = pc + 32'd4;
		@(posedge clk);
		#2;
		retValid = 1'b0;
	endtask

	task automatic checkCounts(input string phase);
		idle(2);
		for (int s = 0; s < 8; s++) begin
			cntSel = insnClass_e'(s);
			#1;
			checkEq(cntValue, modelCnt[s], $sformatf("%s count, class %0d", phase, s));
		end
		idle(1);
	endtask

	always @(posedge clk) begin
		if (traceValid) begin
			if (expQ.size() == 0) begin
				errors++;
				$display("Error at %0t: trace pulse with no retirement pending", $time);
			end else begin
				expRec = expQ.pop_front();
				checkEq(trace.pc, expRec.pc, "trace pc");
				checkEq(trace.instr, expRec.instr, "trace instr");
				checkEq(trace.mnem, expRec.mnem, $sformatf("mnemonic of %h", expRec.instr));
				checkEq(trace.cls, expRec.cls, $sformatf("class of %h", expRec.instr));
			end
		end
		// only the retirement captured on this edge may still be waiting.
		if (expQ.size() > (retValid ? 1 : 0)) begin
			errors++;
			$display("Error at %0t: a retired instruction produced no trace pulse", $time);
			void'(expQ.pop_front());
		end
	end

	initial begin
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not end within %0d cycles", LIMIT);
		$display("Something failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		retValid = 1'b0;
		retPc = '0;
		retInstr = '0;
		cntSel = clsNop;
		rng = 32'd58085;
		pc = 32'h0040_0000;
		errors = 0;
		checks = 0;
		foreach (modelCnt[i]) modelCnt[i] = 0;
		buildSweep();
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;

		foreach (sweep[i]) retire(sweep[i]);
		checkCounts("sweep");
		repeat (N_RAND) retire(pickWord());
		checkCounts("random");
		repeat (N_GAP) begin
			rng = xorshift(rng);
			if (rng[0]) retire(pickWord());
			else idle(1);
		end
		checkCounts("gaps");
		repeat (N_NOP) retire(32'h0);
		checkCounts("nop");
		cntSel = clsNop;
		#1;
		checkEq(cntValue, 255, "NOP counter after saturation");
		idle(2);

		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) $display("Everything OK");
		else $display("Something failed");
		$finish;
	end

endmodule

//--- flist.f
src/mipsPkg.sv
src/instDec.sv
src/traceStage.sv
src/classCounter.sv
src/instTrace.sv
test/instTrace_chk.sv
test/tb_instTrace.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_instTrace
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_instTrace)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1
